/* verilog/mc_fsb_settings.svh */
`ifndef MC_FSB_SETTINGS_SVH
`define MC_FSB_SETTINGS_SVH

// manycore links, each with a forward and a reverse network
`define NUM_LINKS 2
`define NUM_IN (2 * `NUM_LINKS)

// packet widths of the two networks
`define FWD_W 48
`define REV_W 36
`define PAYLOAD_W ((`FWD_W > `REV_W) ? `FWD_W : `REV_W)

// receive depth per channel on the far side, also the starting credit count
`define REMOTE_CREDITS 4

// tag counts channels plus the credit tag
`define TAG_W $clog2(`NUM_IN + 1)
`define CREDIT_W $clog2(`REMOTE_CREDITS + 1)

// fsb framing
`define DEST_W 4
`define DEST_ID 4'd5
`define RING_W 80

`endif

/* verilog/mc_fsb_pkg.sv */
`include "mc_fsb_settings.svh"

package mc_fsb_pkg;

   // request packet on the forward network
   typedef logic [`FWD_W-1:0] fwd_packet_t;

   // return packet on the reverse network
   typedef logic [`REV_W-1:0] rev_packet_t;

   // tunnel payload, short packets zero-extended
   typedef logic [`PAYLOAD_W-1:0] payload_t;

   // channel tag, 2k = link k fwd, 2k+1 = link k rev, NUM_IN = credit word
   typedef logic [`TAG_W-1:0] tag_t;

   // credit count 0 .. REMOTE_CREDITS
   typedef logic [`CREDIT_W-1:0] credit_t;

   // fsb word: destid, cmd, zero fill, tag, payload
   typedef logic [`RING_W-1:0] ring_word_t;

   // transmit sequencer, names what the output register holds
   typedef enum logic [1:0] {TX_IDLE, TX_DATA, TX_CREDIT} tunnel_state_t;

endpackage

/* verilog/tunnel_side_if.sv */
`timescale 1ns/1ps

interface tunnel_side_if
   import mc_fsb_pkg::*;
   ();

   // index 0 forward network, index 1 reverse network

   // adapter toward tunnel
   logic     [1:0] to_tunnel_v;
   payload_t [1:0] to_tunnel_data;
   logic     [1:0] to_tunnel_yumi;

   // tunnel toward adapter
   logic     [1:0] from_tunnel_v;
   payload_t [1:0] from_tunnel_data;
   logic     [1:0] from_tunnel_yumi;

   modport adapter (
      output to_tunnel_v, to_tunnel_data,
      input  to_tunnel_yumi,
      input  from_tunnel_v, from_tunnel_data,
      output from_tunnel_yumi
   );

   modport tunnel (
      input  to_tunnel_v, to_tunnel_data,
      output to_tunnel_yumi,
      output from_tunnel_v, from_tunnel_data,
      input  from_tunnel_yumi
   );

endinterface

/* verilog/two_fifo.sv */
`timescale 1ns/1ps

module two_fifo
   import mc_fsb_pkg::*;
(
   input  logic     clk_i,
   input  logic     reset_i,
   input  logic     v_i,
   input  payload_t data_i,
   output logic     ready_o,
   output logic     v_o,
   output payload_t data_o,
   input  logic     yumi_i
);

   payload_t mem_r [2];
   logic     rd_ptr_r;
   logic     wr_ptr_r;
   logic     full_r;
   logic     empty;
   logic     enq;

   // empty when pointers meet and not full
   assign empty   = (rd_ptr_r == wr_ptr_r) & ~full_r;
   assign v_o     = ~empty;
   assign data_o  = mem_r[rd_ptr_r];

   // a pop in the same cycle frees a slot
   assign ready_o = ~full_r | yumi_i;
   assign enq     = v_i & ready_o;

   always_ff @(posedge clk_i)
   begin
      if (enq)
         mem_r[wr_ptr_r] <= data_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         rd_ptr_r <= 1'b0;
         wr_ptr_r <= 1'b0;
         full_r   <= 1'b0;
      end
      else
      begin
         if (enq)
            wr_ptr_r <= ~wr_ptr_r;
         if (yumi_i)
            rd_ptr_r <= ~rd_ptr_r;
         // fills on push without pop when pointers are one apart
         if (enq & ~yumi_i)
            full_r <= (rd_ptr_r != wr_ptr_r);
         else if (yumi_i & ~enq)
            full_r <= 1'b0;
      end
   end

endmodule

/* verilog/mc_link_adapter.sv */
`timescale 1ns/1ps
`include "mc_fsb_settings.svh"

module mc_link_adapter
   import mc_fsb_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  fwd_v_i,
   input  fwd_packet_t           fwd_data_i,
   output logic                  fwd_ready_o,
   input  logic                  rev_v_i,
   input  rev_packet_t           rev_data_i,
   output logic                  rev_ready_o,
   output logic                  fwd_v_o,
   output fwd_packet_t           fwd_data_o,
   input  logic                  fwd_ready_i,
   output logic                  rev_v_o,
   output rev_packet_t           rev_data_o,
   input  logic                  rev_ready_i,
   tunnel_side_if.adapter        tun
);

   // forward requests from the manycore, one register stage
   two_fifo fwd_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .v_i     (fwd_v_i),
      .data_i  (payload_t'(fwd_data_i)),
      .ready_o (fwd_ready_o),
      .v_o     (tun.to_tunnel_v[0]),
      .data_o  (tun.to_tunnel_data[0]),
      .yumi_i  (tun.to_tunnel_yumi[0])
   );

   // return packets are shorter, upper payload bits zero
   two_fifo rev_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .v_i     (rev_v_i),
      .data_i  (payload_t'(rev_data_i)),
      .ready_o (rev_ready_o),
      .v_o     (tun.to_tunnel_v[1]),
      .data_o  (tun.to_tunnel_data[1]),
      .yumi_i  (tun.to_tunnel_yumi[1])
   );

   // toward the manycore, drop the zero fill
   assign fwd_v_o    = tun.from_tunnel_v[0];
   assign fwd_data_o = tun.from_tunnel_data[0][`FWD_W-1:0];
   assign rev_v_o    = tun.from_tunnel_v[1];
   assign rev_data_o = tun.from_tunnel_data[1][`REV_W-1:0];

   // ready to yumi, consume only when offered and accepted
   assign tun.from_tunnel_yumi[0] = tun.from_tunnel_v[0] & fwd_ready_i;
   assign tun.from_tunnel_yumi[1] = tun.from_tunnel_v[1] & rev_ready_i;

endmodule

/* verilog/tunnel_rx.sv */
`timescale 1ns/1ps
`include "mc_fsb_settings.svh"

module tunnel_rx
   import mc_fsb_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  logic                   in_v_i,
   input  tag_t                   in_tag_i,
   input  payload_t               in_data_i,
   output logic                   in_yumi_o,
   output logic     [`NUM_IN-1:0] chan_v_o,
   output payload_t [`NUM_IN-1:0] chan_data_o,
   input  logic     [`NUM_IN-1:0] chan_yumi_i,
   output logic                   credit_v_o,
   output tag_t                   credit_chan_o,
   output credit_t                credit_cnt_o,
   input  logic                   credit_taken_i,
   output logic                   credit_add_v_o,
   output tag_t                   credit_add_chan_o,
   output credit_t                credit_add_cnt_o
);

   // depth is a power of two so pointers wrap by themselves
   localparam int ptr_w_lp = $clog2(`REMOTE_CREDITS);

   payload_t            buf_r    [`NUM_IN][`REMOTE_CREDITS];
   logic [ptr_w_lp-1:0] rd_ptr_r [`NUM_IN];
   logic [ptr_w_lp-1:0] wr_ptr_r [`NUM_IN];
   credit_t             used_r   [`NUM_IN];
   credit_t             ret_r    [`NUM_IN];
   logic [`NUM_IN-1:0]  wr_en;

   // always accepted, sender credits keep the buffers from overflowing
   assign in_yumi_o = in_v_i;

   // credit words skip the buffers, chan in low bits, count above
   assign credit_add_v_o    = in_v_i & (in_tag_i == tag_t'(`NUM_IN));
   assign credit_add_chan_o = in_data_i[`TAG_W-1:0];
   assign credit_add_cnt_o  = in_data_i[`TAG_W +: `CREDIT_W];

   for (genvar c = 0; c < `NUM_IN; c++)
   begin : g_chan
      assign wr_en[c]       = in_v_i & (in_tag_i == tag_t'(c));
      assign chan_v_o[c]    = (used_r[c] != '0);
      assign chan_data_o[c] = buf_r[c][rd_ptr_r[c]];
   end

   // offer the lowest channel with credits to hand back
   always_comb
   begin
      credit_v_o    = 1'b0;
      credit_chan_o = '0;
      credit_cnt_o  = '0;
      for (int c = `NUM_IN - 1; c >= 0; c--)
      begin
         if (ret_r[c] != '0)
         begin
            credit_v_o    = 1'b1;
            credit_chan_o = tag_t'(c);
            credit_cnt_o  = ret_r[c];
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      for (int c = 0; c < `NUM_IN; c++)
      begin
         if (wr_en[c])
            buf_r[c][wr_ptr_r[c]] <= in_data_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      for (int c = 0; c < `NUM_IN; c++)
      begin
         if (reset_i)
         begin
            rd_ptr_r[c] <= '0;
            wr_ptr_r[c] <= '0;
            used_r[c]   <= '0;
            ret_r[c]    <= '0;
         end
         else
         begin
            if (wr_en[c])
               wr_ptr_r[c] <= wr_ptr_r[c] + 1'b1;
            if (chan_yumi_i[c])
               rd_ptr_r[c] <= rd_ptr_r[c] + 1'b1;
            used_r[c] <= used_r[c] + credit_t'(wr_en[c]) - credit_t'(chan_yumi_i[c]);
            // returned count cleared, a pop this cycle starts the next batch
            if (credit_taken_i && (credit_chan_o == tag_t'(c)))
               ret_r[c] <= credit_t'(chan_yumi_i[c]);
            else if (chan_yumi_i[c])
               ret_r[c] <= ret_r[c] + 1'b1;
         end
      end
   end

endmodule

/* verilog/channel_tunnel.sv */
`timescale 1ns/1ps
`include "mc_fsb_settings.svh"

module channel_tunnel
   import mc_fsb_pkg::*;
(
   input  logic                         clk_i,
   input  logic                         reset_i,
   tunnel_side_if.tunnel                tun [`NUM_LINKS],
   input  logic                         multi_v_i,
   input  logic [`TAG_W+`PAYLOAD_W-1:0] multi_data_i,
   output logic                         multi_yumi_o,
   output logic                         multi_v_o,
   output ring_word_t                   multi_data_o,
   input  logic                         multi_yumi_i
);

   localparam int fill_w_lp = `RING_W - `DEST_W - 1 - `TAG_W - `PAYLOAD_W;
   localparam logic [`DEST_W-1:0] dest_id_lp = `DEST_ID;

   typedef logic [$clog2(`NUM_IN)-1:0] chan_t;

   logic     [`NUM_IN-1:0] in_v;
   payload_t [`NUM_IN-1:0] in_data;
   logic     [`NUM_IN-1:0] in_yumi;
   logic     [`NUM_IN-1:0] out_v;
   payload_t [`NUM_IN-1:0] out_data;
   logic     [`NUM_IN-1:0] out_yumi;
   logic                   credit_v;
   tag_t                   credit_chan;
   credit_t                credit_cnt;
   logic                   credit_taken;
   logic                   credit_add_v;
   tag_t                   credit_add_chan;
   credit_t                credit_add_cnt;
   credit_t                cred_add [`NUM_IN];
   credit_t                cred_r   [`NUM_IN];
   chan_t                  rr_r;
   chan_t                  cand;
   chan_t                  pick;
   logic                   pick_v;
   logic                   load;
   logic                   load_data;
   tunnel_state_t          state_r;
   tunnel_state_t          state_n;
   tag_t                   out_tag_r;
   payload_t               out_pay_r;

   // flatten links into channels 2k and 2k+1
   for (genvar k = 0; k < `NUM_LINKS; k++)
   begin : g_link
      assign in_v[2*k +: 2]          = tun[k].to_tunnel_v;
      assign in_data[2*k +: 2]       = tun[k].to_tunnel_data;
      assign tun[k].to_tunnel_yumi   = in_yumi[2*k +: 2];
      assign tun[k].from_tunnel_v    = out_v[2*k +: 2];
      assign tun[k].from_tunnel_data = out_data[2*k +: 2];
      assign out_yumi[2*k +: 2]      = tun[k].from_tunnel_yumi;
   end

   tunnel_rx rx0 (
      .clk_i             (clk_i),
      .reset_i           (reset_i),
      .in_v_i            (multi_v_i),
      .in_tag_i          (multi_data_i[`PAYLOAD_W +: `TAG_W]),
      .in_data_i         (multi_data_i[`PAYLOAD_W-1:0]),
      .in_yumi_o         (multi_yumi_o),
      .chan_v_o          (out_v),
      .chan_data_o       (out_data),
      .chan_yumi_i       (out_yumi),
      .credit_v_o        (credit_v),
      .credit_chan_o     (credit_chan),
      .credit_cnt_o      (credit_cnt),
      .credit_taken_i    (credit_taken),
      .credit_add_v_o    (credit_add_v),
      .credit_add_chan_o (credit_add_chan),
      .credit_add_cnt_o  (credit_add_cnt)
   );

   // first channel at or after rr_r with data and credit
   always_comb
   begin
      pick_v = 1'b0;
      pick   = rr_r;
      cand   = rr_r;
      for (int i = `NUM_IN - 1; i >= 0; i--)
      begin
         cand = rr_r + chan_t'(i);
         if (in_v[cand] && (cred_r[cand] != '0))
         begin
            pick_v = 1'b1;
            pick   = cand;
         end
      end
   end

   // output register free when empty or taken this cycle
   assign multi_v_o = (state_r != TX_IDLE);
   assign load      = (state_r == TX_IDLE) | multi_yumi_i;

   // credit returns go ahead of data
   always_comb
   begin
      state_n      = state_r;
      credit_taken = 1'b0;
      load_data    = 1'b0;
      if (load)
      begin
         if (credit_v)
         begin
            state_n      = TX_CREDIT;
            credit_taken = 1'b1;
         end
         else if (pick_v)
         begin
            state_n   = TX_DATA;
            load_data = 1'b1;
         end
         else
            state_n = TX_IDLE;
      end
   end

   for (genvar c = 0; c < `NUM_IN; c++)
   begin : g_cred
      assign in_yumi[c]  = load_data & (pick == chan_t'(c));
      assign cred_add[c] = (credit_add_v && (credit_add_chan == tag_t'(c))) ?
                           credit_add_cnt : credit_t'(0);
   end

   // credit word puts count above channel index
   always_ff @(posedge clk_i)
   begin
      if (credit_taken)
      begin
         out_tag_r <= tag_t'(`NUM_IN);
         out_pay_r <= payload_t'({credit_cnt, credit_chan});
      end
      else if (load_data)
      begin
         out_tag_r <= tag_t'(pick);
         out_pay_r <= in_data[pick];
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r <= TX_IDLE;
         rr_r    <= '0;
         for (int c = 0; c < `NUM_IN; c++)
            cred_r[c] <= credit_t'(`REMOTE_CREDITS);
      end
      else
      begin
         state_r <= state_n;
         // next search starts past the winner
         if (load_data)
            rr_r <= pick + 1'b1;
         for (int c = 0; c < `NUM_IN; c++)
            cred_r[c] <= cred_r[c] - credit_t'(in_yumi[c]) + cred_add[c];
      end
   end

   // fsb framing, cmd always zero
   assign multi_data_o = {dest_id_lp, 1'b0, {fill_w_lp{1'b0}}, out_tag_r, out_pay_r};

endmodule

/* verilog/links_to_fsb.sv */
`timescale 1ns/1ps
`include "mc_fsb_settings.svh"

module links_to_fsb
   import mc_fsb_pkg::*;
(
   input  logic                         clk_i,
   input  logic                         reset_i,
   input  logic        [`NUM_LINKS-1:0] link_fwd_v_i,
   input  fwd_packet_t [`NUM_LINKS-1:0] link_fwd_data_i,
   output logic        [`NUM_LINKS-1:0] link_fwd_ready_o,
   input  logic        [`NUM_LINKS-1:0] link_rev_v_i,
   input  rev_packet_t [`NUM_LINKS-1:0] link_rev_data_i,
   output logic        [`NUM_LINKS-1:0] link_rev_ready_o,
   output logic        [`NUM_LINKS-1:0] link_fwd_v_o,
   output fwd_packet_t [`NUM_LINKS-1:0] link_fwd_data_o,
   input  logic        [`NUM_LINKS-1:0] link_fwd_ready_i,
   output logic        [`NUM_LINKS-1:0] link_rev_v_o,
   output rev_packet_t [`NUM_LINKS-1:0] link_rev_data_o,
   input  logic        [`NUM_LINKS-1:0] link_rev_ready_i,
   input  logic                         fsb_v_i,
   input  ring_word_t                   fsb_data_i,
   output logic                         fsb_ready_o,
   output logic                         fsb_v_o,
   output ring_word_t                   fsb_data_o,
   input  logic                         fsb_yumi_i
);

   logic     pay_ready;
   logic     tag_ready;
   logic     pay_v;
   logic     tag_v;
   payload_t pay_data;
   payload_t tag_data;
   logic     multi_yumi;

   tunnel_side_if tun [`NUM_LINKS] ();

   for (genvar k = 0; k < `NUM_LINKS; k++)
   begin : g_adapter
      mc_link_adapter adapter (
         .clk_i       (clk_i),
         .reset_i     (reset_i),
         .fwd_v_i     (link_fwd_v_i[k]),
         .fwd_data_i  (link_fwd_data_i[k]),
         .fwd_ready_o (link_fwd_ready_o[k]),
         .rev_v_i     (link_rev_v_i[k]),
         .rev_data_i  (link_rev_data_i[k]),
         .rev_ready_o (link_rev_ready_o[k]),
         .fwd_v_o     (link_fwd_v_o[k]),
         .fwd_data_o  (link_fwd_data_o[k]),
         .fwd_ready_i (link_fwd_ready_i[k]),
         .rev_v_o     (link_rev_v_o[k]),
         .rev_data_o  (link_rev_data_o[k]),
         .rev_ready_i (link_rev_ready_i[k]),
         .tun         (tun[k])
      );
   end

   // fsb input stage, payload and tag in two fifos that move in lockstep
   // only the low tag and payload bits of the fsb word matter
   two_fifo fsb_pay_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .v_i     (fsb_v_i),
      .data_i  (fsb_data_i[`PAYLOAD_W-1:0]),
      .ready_o (pay_ready),
      .v_o     (pay_v),
      .data_o  (pay_data),
      .yumi_i  (multi_yumi)
   );

   two_fifo fsb_tag_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .v_i     (fsb_v_i),
      .data_i  (payload_t'(fsb_data_i[`PAYLOAD_W +: `TAG_W])),
      .ready_o (tag_ready),
      .v_o     (tag_v),
      .data_o  (tag_data),
      .yumi_i  (multi_yumi)
   );

   assign fsb_ready_o = pay_ready & tag_ready;

   channel_tunnel tunnel (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .tun          (tun),
      .multi_v_i    (pay_v & tag_v),
      .multi_data_i ({tag_data[`TAG_W-1:0], pay_data}),
      .multi_yumi_o (multi_yumi),
      .multi_v_o    (fsb_v_o),
      .multi_data_o (fsb_data_o),
      .multi_yumi_i (fsb_yumi_i)
   );

endmodule

/* verif/links_to_fsb_props.sv */
`timescale 1ns/1ps
`include "mc_fsb_settings.svh"

module links_to_fsb_props
   import mc_fsb_pkg::*;
(
   input logic                         clk_i,
   input logic                         reset_i,
   input logic                         fsb_v_o,
   input ring_word_t                   fsb_data_o,
   input logic                         fsb_yumi_i,
   input logic        [`NUM_LINKS-1:0] link_fwd_v_o,
   input fwd_packet_t [`NUM_LINKS-1:0] link_fwd_data_o,
   input logic        [`NUM_LINKS-1:0] link_fwd_ready_i,
   input logic        [`NUM_LINKS-1:0] link_rev_v_o,
   input rev_packet_t [`NUM_LINKS-1:0] link_rev_data_o,
   input logic        [`NUM_LINKS-1:0] link_rev_ready_i
);

   // stalled fsb word holds
   assert property (@(posedge clk_i) disable iff (reset_i)
      (fsb_v_o && !fsb_yumi_i) |=> (fsb_v_o && $stable(fsb_data_o)))
      else $error("fsb output word changed while stalled");

   // nothing leaves right after reset
   assert property (@(posedge clk_i) reset_i |=> !fsb_v_o)
      else $error("fsb valid high in the cycle after reset");

   for (genvar k = 0; k < `NUM_LINKS; k++)
   begin : g_link
      assert property (@(posedge clk_i) disable iff (reset_i)
         (link_fwd_v_o[k] && !link_fwd_ready_i[k]) |=>
         (link_fwd_v_o[k] && $stable(link_fwd_data_o[k])))
         else $error("link forward output changed while not ready");
      assert property (@(posedge clk_i) disable iff (reset_i)
         (link_rev_v_o[k] && !link_rev_ready_i[k]) |=>
         (link_rev_v_o[k] && $stable(link_rev_data_o[k])))
         else $error("link reverse output changed while not ready");
   end

endmodule

bind links_to_fsb links_to_fsb_props props0 (
   .clk_i            (clk_i),
   .reset_i          (reset_i),
   .fsb_v_o          (fsb_v_o),
   .fsb_data_o       (fsb_data_o),
   .fsb_yumi_i       (fsb_yumi_i),
   .link_fwd_v_o     (link_fwd_v_o),
   .link_fwd_data_o  (link_fwd_data_o),
   .link_fwd_ready_i (link_fwd_ready_i),
   .link_rev_v_o     (link_rev_v_o),
   .link_rev_data_o  (link_rev_data_o),
   .link_rev_ready_i (link_rev_ready_i)
);

/* verif/tb_links_to_fsb.sv */
`timescale 1ns/1ps
`include "mc_fsb_settings.svh"

module tb_links_to_fsb
   import mc_fsb_pkg::*;
   ();

   localparam int pkts_lp    = 40;
   localparam int timeout_lp = 20000;
   localparam int fill_w_lp  = `RING_W - `DEST_W - 1 - `TAG_W - `PAYLOAD_W;

   logic                         clk_i;
   logic                         reset_i;
   logic        [`NUM_LINKS-1:0] link_fwd_v_i;
   fwd_packet_t [`NUM_LINKS-1:0] link_fwd_data_i;
   logic        [`NUM_LINKS-1:0] link_fwd_ready_o;
   logic        [`NUM_LINKS-1:0] link_rev_v_i;
   rev_packet_t [`NUM_LINKS-1:0] link_rev_data_i;
   logic        [`NUM_LINKS-1:0] link_rev_ready_o;
   logic        [`NUM_LINKS-1:0] link_fwd_v_o;
   fwd_packet_t [`NUM_LINKS-1:0] link_fwd_data_o;
   logic        [`NUM_LINKS-1:0] link_fwd_ready_i;
   logic        [`NUM_LINKS-1:0] link_rev_v_o;
   rev_packet_t [`NUM_LINKS-1:0] link_rev_data_o;
   logic        [`NUM_LINKS-1:0] link_rev_ready_i;
   logic                         fsb_v_i;
   ring_word_t                   fsb_data_i;
   logic                         fsb_ready_o;
   logic                         fsb_v_o;
   ring_word_t                   fsb_data_o;
   logic                         fsb_yumi_i;

   // remote tunnel model
   payload_t up_q      [`NUM_IN][$];
   payload_t down_q    [`NUM_IN][$];
   int       up_sent   [`NUM_IN];
   int       down_sent [`NUM_IN];
   int       tx_cred   [`NUM_IN];
   int       held      [`NUM_IN];
   int       consumed  [`NUM_IN];
   int       returned  [`NUM_IN];
   // transfer seen before the coming edge
   logic [`NUM_LINKS-1:0] fwd_acc;
   logic [`NUM_LINKS-1:0] rev_acc;
   logic                  fsb_acc;
   int                    cycles;

   links_to_fsb dut0 (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .link_fwd_v_i     (link_fwd_v_i),
      .link_fwd_data_i  (link_fwd_data_i),
      .link_fwd_ready_o (link_fwd_ready_o),
      .link_rev_v_i     (link_rev_v_i),
      .link_rev_data_i  (link_rev_data_i),
      .link_rev_ready_o (link_rev_ready_o),
      .link_fwd_v_o     (link_fwd_v_o),
      .link_fwd_data_o  (link_fwd_data_o),
      .link_fwd_ready_i (link_fwd_ready_i),
      .link_rev_v_o     (link_rev_v_o),
      .link_rev_data_o  (link_rev_data_o),
      .link_rev_ready_i (link_rev_ready_i),
      .fsb_v_i          (fsb_v_i),
      .fsb_data_i       (fsb_data_i),
      .fsb_ready_o      (fsb_ready_o),
      .fsb_v_o          (fsb_v_o),
      .fsb_data_o       (fsb_data_o),
      .fsb_yumi_i       (fsb_yumi_i)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   task automatic abort_run(input string why);
      $display("sim failed");
      $fatal(1, "%s", why);
   endtask

   task automatic check_eq(input string name, input ring_word_t got, input ring_word_t exp);
      if (got !== exp)
      begin
         $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
         abort_run("value mismatch");
      end
   endtask

   // new stimulus only once the previous item has gone
   task automatic drive_inputs;
      int start;
      int mode;
      int pick;
      int c;
      for (int k = 0; k < `NUM_LINKS; k++)
      begin
         if (!link_fwd_v_i[k] || fwd_acc[k])
         begin
            link_fwd_v_i[k] = 1'b0;
            if (up_sent[2*k] < pkts_lp && $urandom_range(1, 0) == 1)
            begin
               link_fwd_v_i[k]    = 1'b1;
               link_fwd_data_i[k] = fwd_packet_t'({$urandom, $urandom});
               up_sent[2*k]++;
            end
         end
         if (!link_rev_v_i[k] || rev_acc[k])
         begin
            link_rev_v_i[k] = 1'b0;
            if (up_sent[2*k+1] < pkts_lp && $urandom_range(1, 0) == 1)
            begin
               link_rev_v_i[k]    = 1'b1;
               link_rev_data_i[k] = rev_packet_t'({$urandom, $urandom});
               up_sent[2*k+1]++;
            end
         end
         fwd_acc[k]          = 1'b0;
         rev_acc[k]          = 1'b0;
         link_fwd_ready_i[k] = ($urandom_range(3, 0) != 0);
         link_rev_ready_i[k] = ($urandom_range(3, 0) != 0);
      end
      // yumi only with a valid word
      fsb_yumi_i = fsb_v_o & ($urandom_range(2, 0) != 0);
      if (!fsb_v_i || fsb_acc)
      begin
         fsb_v_i = 1'b0;
         start   = $urandom_range(`NUM_IN - 1, 0);
         mode    = $urandom_range(3, 0);
         pick    = -1;
         // credit return with random delay
         if (mode == 0)
         begin
            for (int i = 0; i < `NUM_IN; i++)
            begin
               c = (start + i) % `NUM_IN;
               if (pick < 0 && held[c] > 0)
                  pick = c;
            end
            if (pick >= 0)
            begin
               fsb_v_i    = 1'b1;
               fsb_data_i = {`DEST_ID, 1'b0, {fill_w_lp{1'b0}}, tag_t'(`NUM_IN),
                             payload_t'({credit_t'(held[pick]), tag_t'(pick)})};
            end
         end
         else if (mode < 3)
         begin
            for (int i = 0; i < `NUM_IN; i++)
            begin
               c = (start + i) % `NUM_IN;
               if (pick < 0 && tx_cred[c] > 0 && down_sent[c] < pkts_lp)
                  pick = c;
            end
            if (pick >= 0)
            begin
               // random cmd bit which the design ignores
               fsb_v_i    = 1'b1;
               fsb_data_i = {`DEST_ID, ($urandom_range(1, 0) == 1), {fill_w_lp{1'b0}},
                             tag_t'(pick), payload_t'({$urandom, $urandom})};
               tx_cred[pick]--;
               down_sent[pick]++;
            end
         end
      end
      fsb_acc = 1'b0;
   endtask

   // transfers seen here happen at the next rising edge
   task automatic observe_transfers;
      payload_t pay;
      int       tag;
      int       chan;
      int       cnt;
      for (int k = 0; k < `NUM_LINKS; k++)
      begin
         if (link_fwd_v_i[k] && link_fwd_ready_o[k])
         begin
            up_q[2*k].push_back(payload_t'(link_fwd_data_i[k]));
            fwd_acc[k] = 1'b1;
         end
         if (link_rev_v_i[k] && link_rev_ready_o[k])
         begin
            up_q[2*k+1].push_back(payload_t'(link_rev_data_i[k]));
            rev_acc[k] = 1'b1;
         end
         if (link_fwd_v_o[k] && link_fwd_ready_i[k])
         begin
            if (down_q[2*k].size() == 0)
               abort_run("a link forward output gave a word that was never sent");
            pay = down_q[2*k].pop_front();
            check_eq("link_fwd_data_o", ring_word_t'(link_fwd_data_o[k]),
                     ring_word_t'(pay[`FWD_W-1:0]));
            consumed[2*k]++;
         end
         if (link_rev_v_o[k] && link_rev_ready_i[k])
         begin
            if (down_q[2*k+1].size() == 0)
               abort_run("a link reverse output gave a word that was never sent");
            pay = down_q[2*k+1].pop_front();
            check_eq("link_rev_data_o", ring_word_t'(link_rev_data_o[k]),
                     ring_word_t'(pay[`REV_W-1:0]));
            consumed[2*k+1]++;
         end
      end
      // credit words on the fsb input release remote buffer space
      if (fsb_v_i && fsb_ready_o)
      begin
         tag = int'(fsb_data_i[`PAYLOAD_W +: `TAG_W]);
         if (tag == `NUM_IN)
            held[int'(fsb_data_i[`TAG_W-1:0])] -= int'(fsb_data_i[`TAG_W +: `CREDIT_W]);
         else
            down_q[tag].push_back(fsb_data_i[`PAYLOAD_W-1:0]);
         fsb_acc = 1'b1;
      end
      if (fsb_v_o && fsb_yumi_i)
      begin
         check_eq("fsb_data_o.dest", ring_word_t'(fsb_data_o[`RING_W-1 -: `DEST_W]),
                  ring_word_t'(`DEST_ID));
         check_eq("fsb_data_o.cmd", ring_word_t'(fsb_data_o[`RING_W-`DEST_W-1]), '0);
         check_eq("fsb_data_o.fill",
                  ring_word_t'(fsb_data_o[`RING_W-`DEST_W-2 : `PAYLOAD_W+`TAG_W]), '0);
         tag = int'(fsb_data_o[`PAYLOAD_W +: `TAG_W]);
         if (tag < `NUM_IN)
         begin
            if (up_q[tag].size() == 0)
               abort_run("the fsb output carried a data word that no link sent");
            pay = up_q[tag].pop_front();
            check_eq("fsb_data_o.payload", ring_word_t'(fsb_data_o[`PAYLOAD_W-1:0]),
                     ring_word_t'(pay));
            held[tag]++;
            if (held[tag] > `REMOTE_CREDITS)
               abort_run("more data words in flight on a channel than it has credits");
         end
         else if (tag == `NUM_IN)
         begin
            chan = int'(fsb_data_o[`TAG_W-1:0]);
            cnt  = int'(fsb_data_o[`TAG_W +: `CREDIT_W]);
            if (chan >= `NUM_IN || cnt == 0)
               abort_run("a credit word named a bad channel or an empty count");
            returned[chan] += cnt;
            tx_cred[chan]  += cnt;
            if (returned[chan] > consumed[chan])
               abort_run("more credits returned than words consumed on a channel");
         end
         else
            abort_run("the fsb output carried an unknown tag");
      end
   endtask

   function automatic logic drained();
      logic ok;
      ok = (!fsb_v_i || fsb_acc) && (!fsb_v_o || fsb_yumi_i) &&
           ((link_fwd_v_i & ~fwd_acc) == '0) && ((link_rev_v_i & ~rev_acc) == '0);
      for (int c = 0; c < `NUM_IN; c++)
      begin
         ok = ok && (up_sent[c] == pkts_lp) && (down_sent[c] == pkts_lp) &&
              (up_q[c].size() == 0) && (down_q[c].size() == 0) &&
              (held[c] == 0) && (tx_cred[c] == `REMOTE_CREDITS);
      end
      return ok;
   endfunction

   initial
   begin
      void'($urandom(32'hfc2b_f0f6));
      reset_i          = 1'b1;
      link_fwd_v_i     = '0;
      link_fwd_data_i  = '0;
      link_rev_v_i     = '0;
      link_rev_data_i  = '0;
      link_fwd_ready_i = '0;
      link_rev_ready_i = '0;
      fsb_v_i          = 1'b0;
      fsb_data_i       = '0;
      fsb_yumi_i       = 1'b0;
      fwd_acc          = '0;
      rev_acc          = '0;
      fsb_acc          = 1'b0;
      for (int c = 0; c < `NUM_IN; c++)
      begin
         up_sent[c]   = 0;
         down_sent[c] = 0;
         tx_cred[c]   = `REMOTE_CREDITS;
         held[c]      = 0;
         consumed[c]  = 0;
         returned[c]  = 0;
      end
      repeat (3) @(negedge clk_i);
      reset_i = 1'b0;
      // out of reset the fifos are empty and nothing is offered
      check_eq("link_fwd_ready_o", ring_word_t'(link_fwd_ready_o),
               ring_word_t'({`NUM_LINKS{1'b1}}));
      check_eq("link_rev_ready_o", ring_word_t'(link_rev_ready_o),
               ring_word_t'({`NUM_LINKS{1'b1}}));
      check_eq("fsb_ready_o", ring_word_t'(fsb_ready_o), ring_word_t'(1'b1));
      check_eq("link_fwd_v_o", ring_word_t'(link_fwd_v_o), '0);
      check_eq("link_rev_v_o", ring_word_t'(link_rev_v_o), '0);
      check_eq("fsb_v_o", ring_word_t'(fsb_v_o), '0);
      cycles  = 0;
      while (!drained())
      begin
         if (cycles == timeout_lp)
            abort_run("timed out waiting for all traffic and credits to drain");
         @(negedge clk_i);
         drive_inputs();
         #1;
         observe_transfers();
         cycles++;
      end
      $display("sim passed");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+verilog
verilog/mc_fsb_pkg.sv
verilog/tunnel_side_if.sv
verilog/two_fifo.sv
verilog/mc_link_adapter.sv
verilog/tunnel_rx.sv
verilog/channel_tunnel.sv
verilog/links_to_fsb.sv
verif/links_to_fsb_props.sv
verif/tb_links_to_fsb.sv

/* Makefile */
# Verilator simulation of the manycore to FSB link subsystem
# any variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_links_to_fsb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: sim clean

# build and run, exit status follows the testbench
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
